// ==== rtl/ramio_pkg.sv ====
// ----------------------------------------------------------
// shared types and constants of the bus bridge
// I/O addresses sit at the top of the map, all else is RAM
// RAM aliases every RAM_WORDS*4 bytes, no range check
// ----------------------------------------------------------
package ramio_pkg;

  // client bus word, data and address
  typedef logic [31:0] word_t;

  // bit 2 sign extend, low bits 01 byte, 10 half, 11 word
  typedef logic [2:0] read_type_t;

  // 01 byte, 10 half, 11 word, 00 no write
  typedef logic [1:0] write_type_t;

  // one write enable per byte lane
  typedef logic [3:0] byte_en_t;

  // led levels, 0 is lit
  typedef logic [3:0] led_t;

  // memory-mapped I/O
  localparam word_t ADDR_LED      = 32'hffff_fffc;
  localparam word_t ADDR_UART_OUT = 32'hffff_fff8;
  localparam word_t ADDR_UART_IN  = 32'hffff_fff4;

  // on-chip RAM geometry
  localparam int RAM_WORDS   = 256;
  localparam int RAM_INDEX_W = $clog2(RAM_WORDS);
  typedef logic [RAM_INDEX_W-1:0] ram_index_t;

  // uart bit time in clocks, kept small for simulation
  localparam int CLKS_PER_BIT = 16;
  localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
  typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;

  // uart words read as this when empty
  localparam word_t UART_IDLE = 32'hffff_ffff;

endpackage

// ==== rtl/ramio_if.sv ====
// ----------------------------------------------------------
// internal links of the bridge: bus front to RAM and to I/O
// all strobes are levels, valid while the client holds enable
// ----------------------------------------------------------
`timescale 1ns/1ns

// word RAM port, rdata valid one cycle after en
interface mem_if import ramio_pkg::*; ();
  logic       en;
  ram_index_t index;
  word_t      wdata;
  byte_en_t   be;
  word_t      rdata;

  modport host (output en, index, wdata, be, input rdata);
  modport ram (input en, index, wdata, be, output rdata);
endinterface

// I/O register port
interface io_if import ramio_pkg::*; ();
  logic  wr_led;
  logic  wr_uart_out;
  logic  rd_uart_in;
  word_t wdata;
  word_t uart_out_word;
  word_t uart_in_word;

  modport host (output wr_led, wr_uart_out, rd_uart_in, wdata,
                input uart_out_word, uart_in_word);
  modport regs (input wr_led, wr_uart_out, rd_uart_in, wdata,
                output uart_out_word, uart_in_word);
endinterface

// ==== rtl/word_ram.sv ====
// ----------------------------------------------------------
// single-port word RAM with byte-lane writes
// read data registered, old contents on a write cycle
// ----------------------------------------------------------
`timescale 1ns/1ns

module word_ram import ramio_pkg::*; (
  input logic clk,
  mem_if.ram  mem
);

  word_t mem_array [RAM_WORDS];

  // write enabled lanes, read whole word
  always_ff @(posedge clk) begin
    if (mem.en) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (mem.be[lane]) begin
          mem_array[mem.index][lane*8 +: 8] <= mem.wdata[lane*8 +: 8];
        end
      end
      mem.rdata <= mem_array[mem.index];
    end
  end

endmodule

// ==== rtl/io_regs.sv ====
// ----------------------------------------------------------
// LED nibble and the two uart holding words
// uart out write ignored while a frame is in flight
// unread rx byte is overwritten by the next one
// ----------------------------------------------------------
`timescale 1ns/1ns

module io_regs import ramio_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  io_if.regs         io,
  output led_t       led,
  output logic       tx_go,
  output logic [7:0] tx_data,
  input  logic       tx_busy,
  output logic       rx_go,
  input  logic       rx_ready,
  input  logic [7:0] rx_data
);

  // transmitter sends the held byte
  assign tx_data = io.uart_out_word[7:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led              <= 4'b1111;
      tx_go            <= 1'b0;
      io.uart_out_word <= UART_IDLE;
      rx_go            <= 1'b1;
      io.uart_in_word  <= UART_IDLE;
    end else begin
      // leds, all off after reset
      if (io.wr_led) begin
        led <= io.wdata[3:0];
      end

      // ---------------------------------------------------
      // transmit handshake
      // ---------------------------------------------------
      // busy dropped, frame done, release go
      if (tx_go && !tx_busy) begin
        tx_go            <= 1'b0;
        io.uart_out_word <= UART_IDLE;
      end
      // new byte only when transmitter fully idle
      if (io.wr_uart_out && !tx_go && !tx_busy) begin
        tx_go            <= 1'b1;
        io.uart_out_word <= {24'h0, io.wdata[7:0]};
      end

      // ---------------------------------------------------
      // receive handshake
      // ---------------------------------------------------
      // read empties the word
      if (io.rd_uart_in) begin
        io.uart_in_word <= UART_IDLE;
      end
      // copy byte, ack by dropping go one cycle
      if (rx_go && rx_ready) begin
        io.uart_in_word <= {24'h0, rx_data};
        rx_go           <= 1'b0;
      end
      if (!rx_go) begin
        rx_go <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/uart_tx.sv ====
// ----------------------------------------------------------
// 8N1 serializer, CLKS_PER_BIT clocks per bit
// data sampled once when go is seen while idle
// waits for go low before the next frame
// ----------------------------------------------------------
`timescale 1ns/1ns

module uart_tx import ramio_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       go,
  input  logic [7:0] data,
  output logic       busy,
  output logic       tx
);

  typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_DONE} tx_state_t;

  tx_state_t  state;
  baud_cnt_t  clk_cnt;
  logic [3:0] bit_cnt;
  logic [8:0] shreg;

  // busy from the accepting cycle until the stop bit ends
  assign busy = (state == ST_SHIFT) || (state == ST_IDLE && go);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      tx      <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
      shreg   <= '1;
    end else begin
      case (state)
        ST_IDLE: if (go) begin
          // start bit now, data and stop bit queued
          tx      <= 1'b0;
          shreg   <= {1'b1, data};
          clk_cnt <= '0;
          bit_cnt <= '0;
          state   <= ST_SHIFT;
        end
        ST_SHIFT: if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
          clk_cnt <= '0;
          if (bit_cnt == 4'd9) begin
            state <= ST_DONE;
          end else begin
            tx      <= shreg[0];
            shreg   <= {1'b1, shreg[8:1]};
            bit_cnt <= bit_cnt + 4'd1;
          end
        end else begin
          clk_cnt <= clk_cnt + 1'b1;
        end
        // handshake tail
        default: if (!go) state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/uart_rx.sv ====
// ----------------------------------------------------------
// 8N1 receiver, samples each bit at mid period
// listens only while go is high
// data_ready holds until go drops
// ----------------------------------------------------------
`timescale 1ns/1ns

module uart_rx import ramio_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       go,
  output logic [7:0] data,
  output logic       data_ready
);

  typedef enum logic [2:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP, ST_READY} rx_state_t;

  rx_state_t  state;
  logic [1:0] rx_sync;
  logic       rx_prev;
  baud_cnt_t  clk_cnt;
  logic [2:0] bit_cnt;

  assign data_ready = state == ST_READY;

  // two-flop sync plus previous level for edge detect
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;
      rx_prev <= 1'b1;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      rx_prev <= rx_sync[1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: if (go && rx_prev && !rx_sync[1]) begin
          clk_cnt <= '0;
          state   <= ST_START;
        end
        // half a bit in, still low or a glitch
        ST_START: if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1)) begin
          clk_cnt <= '0;
          bit_cnt <= '0;
          state   <= rx_sync[1] ? ST_IDLE : ST_DATA;
        end else begin
          clk_cnt <= clk_cnt + 1'b1;
        end
        // lsb first, one full bit apart
        ST_DATA: if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
          clk_cnt <= '0;
          data    <= {rx_sync[1], data[7:1]};
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) state <= ST_STOP;
        end else begin
          clk_cnt <= clk_cnt + 1'b1;
        end
        // stop level is not checked
        ST_STOP: if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
          state <= ST_READY;
        end else begin
          clk_cnt <= clk_cnt + 1'b1;
        end
        default: if (!go) state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/bus_front.sv ====
// ----------------------------------------------------------
// client bus decode and lane conversion
// misaligned half word: write dropped, read gives zero
// misaligned word uses the whole word
// ----------------------------------------------------------
`timescale 1ns/1ns

module bus_front import ramio_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  read_type_t  read_type,
  input  write_type_t write_type,
  input  word_t       address,
  input  word_t       data_in,
  output word_t       data_out,
  output logic        data_out_ready,
  mem_if.host         mem,
  io_if.host          io
);

  logic        is_led;
  logic        is_uart_out;
  logic        is_uart_in;
  logic        is_io;
  logic        is_read;
  logic        is_write;
  logic        ram_acc;
  logic        ram_seen;
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;

  // ---------------------------------------------------------
  // decode
  // ---------------------------------------------------------
  assign is_led      = address == ADDR_LED;
  assign is_uart_out = address == ADDR_UART_OUT;
  assign is_uart_in  = address == ADDR_UART_IN;
  assign is_io       = is_led || is_uart_out || is_uart_in;
  assign is_read     = read_type != '0;
  assign is_write    = write_type != '0;
  assign ram_acc     = enable && !is_io && (is_read || is_write);

  // io strobes, levels while enable held
  assign io.wr_led      = enable && is_write && is_led;
  assign io.wr_uart_out = enable && is_write && is_uart_out;
  assign io.rd_uart_in  = enable && is_read && is_uart_in;
  assign io.wdata       = data_in;

  // ram access seen, holds until enable drops
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ram_seen <= 1'b0;
    end else if (!enable) begin
      ram_seen <= 1'b0;
    end else if (ram_acc) begin
      ram_seen <= 1'b1;
    end
  end

  // one ram cycle per access, rdata then holds
  assign mem.en    = ram_acc && !ram_seen;
  assign mem.index = address[RAM_INDEX_W+1:2];

  // io answers at once, ram one cycle later
  assign data_out_ready = enable && (is_io || ram_seen);

  // ---------------------------------------------------------
  // write lanes
  // ---------------------------------------------------------
  always_comb begin
    mem.be    = '0;
    mem.wdata = data_in;
    case (write_type)
      2'b01: begin
        mem.be    = byte_en_t'(4'b0001 << address[1:0]);
        mem.wdata = {4{data_in[7:0]}};
      end
      2'b10: begin
        // only offsets 0 and 2
        mem.be    = address[0] ? 4'b0000 : (address[1] ? 4'b1100 : 4'b0011);
        mem.wdata = {2{data_in[15:0]}};
      end
      2'b11: mem.be = 4'b1111;
      default: mem.be = '0;
    endcase
  end

  // ---------------------------------------------------------
  // read mux
  // ---------------------------------------------------------
  assign rd_byte = mem.rdata[{address[1:0], 3'b000} +: 8];
  assign rd_half = mem.rdata[{address[1], 4'b0000} +: 16];

  always_comb begin
    data_out = '0;
    if (enable && is_read) begin
      if (is_uart_out) begin
        data_out = io.uart_out_word;
      end else if (is_uart_in) begin
        data_out = io.uart_in_word;
      end else if (!is_led) begin
        case (read_type[1:0])
          2'b01: data_out = {{24{read_type[2] & rd_byte[7]}}, rd_byte};
          2'b10: data_out = address[0] ? '0 : {{16{read_type[2] & rd_half[15]}}, rd_half};
          default: data_out = mem.rdata;
        endcase
      end
    end
  end

endmodule

// ==== rtl/ramio.sv ====
// ----------------------------------------------------------
// bus bridge top: client bus to word RAM, LEDs and UART
// client holds all inputs until data_out_ready
// no busy output, the RAM never stalls
// ----------------------------------------------------------
`timescale 1ns/1ns

module ramio import ramio_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  read_type_t  read_type,
  input  write_type_t write_type,
  input  word_t       address,
  input  word_t       data_in,
  output word_t       data_out,
  output logic        data_out_ready,
  output led_t        led,
  output logic        uart_tx,
  input  logic        uart_rx
);

  mem_if mem ();
  io_if  io ();

  // uart handshake wires
  logic       tx_go;
  logic [7:0] tx_data;
  logic       tx_busy;
  logic       rx_go;
  logic       rx_ready;
  logic [7:0] rx_data;

  bus_front u_bus_front (
    .clk, .rst_n,
    .enable, .read_type, .write_type, .address, .data_in,
    .data_out, .data_out_ready,
    .mem (mem.host),
    .io  (io.host)
  );

  word_ram u_word_ram (
    .clk,
    .mem (mem.ram)
  );

  io_regs u_io_regs (
    .clk, .rst_n,
    .io (io.regs),
    .led,
    .tx_go, .tx_data, .tx_busy,
    .rx_go, .rx_ready, .rx_data
  );

  uart_tx u_uart_tx (
    .clk, .rst_n,
    .go (tx_go), .data (tx_data), .busy (tx_busy), .tx (uart_tx)
  );

  uart_rx u_uart_rx (
    .clk, .rst_n,
    .rx (uart_rx), .go (rx_go), .data (rx_data), .data_ready (rx_ready)
  );

endmodule

// ==== dv/tb_clk.sv ====
// ----------------------------------------------------------
// free-running testbench clock, 20 ns period
// starts low, first rising edge at 10 ns
// ----------------------------------------------------------
`timescale 1ns/1ns

module tb_clk (
  output logic clk
);

  localparam int HALF_NS = 10;

  initial begin
    clk = 1'b0;
  end

  always #(HALF_NS) clk = ~clk;

endmodule

// ==== dv/ramio_sva.sv ====
// ----------------------------------------------------------
// port-level checks on the bridge top bound into ramio
// I/O answers in the access cycle and the tx line idles in reset
// ----------------------------------------------------------
`timescale 1ns/1ns

module ramio_sva import ramio_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  input logic  enable,
  input word_t address,
  input logic  data_out_ready,
  input logic  uart_tx
);

  logic is_io;
  logic in_reset_d;

  assign is_io = (address == ADDR_LED) || (address == ADDR_UART_OUT) ||
                 (address == ADDR_UART_IN);

  // reset held for at least one earlier edge
  always_ff @(posedge clk) begin
    in_reset_d <= !rst_n;
  end

  // I/O access is acknowledged in its own cycle
  io_ready_same_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (enable && is_io) |-> data_out_ready)
    else $error("I/O access without data_out_ready in the same cycle");

  // line idle during reset
  tx_idle_in_reset: assert property (@(posedge clk)
    (!rst_n && in_reset_d) |-> uart_tx)
    else $error("uart_tx low while reset is active");

endmodule

bind ramio ramio_sva u_sva (.*);

// ==== dv/ramio_tb.sv ====
// ----------------------------------------------------------
// testbench for the bus bridge with uart_tx looped to uart_rx
// RAM tests only read words that were written first
// ----------------------------------------------------------
`timescale 1ns/1ns

module ramio_tb import ramio_pkg::*; ();

  localparam int unsigned SEED = 32'hfae6_b0aa;
  localparam int CLK_NS    = 20;
  localparam int N_RAND    = 16;
  localparam int N_MISAL   = 4;
  localparam int N_BYTES   = 2;
  // worst case cycles per bus access including the idle gap
  localparam int BUS_CYC   = 4;
  localparam int FRAME_CYC = 10 * CLKS_PER_BIT;
  localparam int MAX_POLLS = FRAME_CYC / 2 + 16;
  // reset then the led, ram word, lane, misaligned and uart tests
  localparam int TEST_CYC  = 8 + BUS_CYC * 3 + BUS_CYC * 2 * N_RAND + BUS_CYC * 4 * N_RAND +
                             BUS_CYC * 4 * N_MISAL + BUS_CYC * 2 +
                             N_BYTES * (FRAME_CYC + BUS_CYC * 4);
  localparam int TIMEOUT_NS = TEST_CYC * 3 / 2 * CLK_NS;

  logic        clk;
  logic        rst_n;
  logic        enable;
  read_type_t  read_type;
  write_type_t write_type;
  word_t       address;
  word_t       data_in;
  word_t       data_out;
  logic        data_out_ready;
  led_t        led;
  logic        uart_line;

  // memory model with one word per RAM index
  word_t model [RAM_WORDS];
  word_t addrs [$];

  // pending checks filled by stimulus and drained by compare
  word_t got_q  [$];
  word_t exp_q  [$];
  string what_q [$];
  bit    led_q  [$];

  int    err_count;
  int    check_count;
  int    test_count;
  int    test_fail;
  int    test_err_start;
  string test_name;

  tb_clk u_clk (.clk(clk));

  ramio uut (
    .clk, .rst_n,
    .enable, .read_type, .write_type, .address, .data_in,
    .data_out, .data_out_ready,
    .led,
    .uart_tx (uart_line),
    .uart_rx (uart_line)
  );

  // ---------------------------------------------------------
  // reference model
  // ---------------------------------------------------------
  // byte and aligned half replace their lanes and an odd half is dropped
  function automatic word_t merge_write(word_t old, write_type_t wt, logic [1:0] off,
                                        word_t data);
    word_t res;
    res = old;
    case (wt)
      2'b01: res[int'(off) * 8 +: 8] = data[7:0];
      2'b10: if (!off[0]) res[int'(off) * 8 +: 16] = data[15:0];
      2'b11: res = data;
      default: res = old;
    endcase
    return res;
  endfunction

  // pick the lane and fill with zeros or the sign bit
  // odd half word reads zero
  function automatic word_t expect_read(word_t w, read_type_t rt, logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    word_t       res;
    res = w;
    if (rt[1:0] == 2'b01) begin
      b = w[int'(off) * 8 +: 8];
      res = (rt[2] && b[7]) ? {24'hff_ffff, b} : {24'h0, b};
    end else if (rt[1:0] == 2'b10) begin
      if (off[0]) begin
        res = '0;
      end else begin
        h = w[int'(off) * 8 +: 16];
        res = (rt[2] && h[15]) ? {16'hffff, h} : {16'h0, h};
      end
    end
    return res;
  endfunction

  // ---------------------------------------------------------
  // compare and report
  // ---------------------------------------------------------
  task automatic check_word(string what, word_t got, word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_led(string what, led_t got, led_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_error(string msg);
    err_count++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic queue_check(bit is_led, string what, word_t got, word_t exp);
    led_q.push_back(is_led);
    what_q.push_back(what);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  initial begin : compare
    word_t g;
    word_t e;
    string w;
    bit    l;
    forever begin
      @(negedge clk);
      while (got_q.size() > 0) begin
        g = got_q.pop_front();
        e = exp_q.pop_front();
        w = what_q.pop_front();
        l = led_q.pop_front();
        if (l) begin
          check_led(w, g[3:0], e[3:0]);
        end else begin
          check_word(w, g, e);
        end
      end
    end
  end

  task automatic begin_test(string name);
    test_name = name;
    test_err_start = err_count;
  endtask

  // waits for the compare process and prints one line per test
  task automatic end_test();
    while (got_q.size() > 0) begin
      @(posedge clk);
    end
    test_count++;
    if (err_count != test_err_start) begin
      test_fail++;
      $display("test %-10s failed, %0d errors", test_name, err_count - test_err_start);
    end else begin
      $display("test %-10s passed", test_name);
    end
  endtask

  // ---------------------------------------------------------
  // bus driver
  // ---------------------------------------------------------
  // drive after the edge and hold until data_out_ready
  task automatic bus_access(input read_type_t rt, input write_type_t wt, input word_t addr,
                            input word_t wdata, output word_t rdata);
    int waited;
    waited = 0;
    rdata = '0;
    @(posedge clk);
    #2;
    enable = 1'b1;
    read_type = rt;
    write_type = wt;
    address = addr;
    data_in = wdata;
    @(negedge clk);
    while (!data_out_ready && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    if (data_out_ready) begin
      rdata = data_out;
    end else begin
      report_error($sformatf("no data_out_ready for address %h", addr));
    end
    @(posedge clk);
    #2;
    enable = 1'b0;
    read_type = '0;
    write_type = '0;
  endtask

  task automatic ram_write(write_type_t wt, word_t addr, word_t data);
    word_t      rd;
    ram_index_t idx;
    idx = addr[RAM_INDEX_W+1:2];
    bus_access(3'b000, wt, addr, data, rd);
    model[idx] = merge_write(model[idx], wt, addr[1:0], data);
  endtask

  task automatic ram_read_check(read_type_t rt, word_t addr);
    word_t      rd;
    ram_index_t idx;
    idx = addr[RAM_INDEX_W+1:2];
    bus_access(rt, 2'b00, addr, '0, rd);
    queue_check(1'b0, "data_out", rd, expect_read(model[idx], rt, addr[1:0]));
  endtask

  task automatic io_read_check(word_t addr, word_t exp, string what);
    word_t rd;
    bus_access(3'b011, 2'b00, addr, '0, rd);
    queue_check(1'b0, what, rd, exp);
  endtask

  // ---------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------
  initial begin : stimulus
    int unsigned seed_val;
    int          pick;
    int          polls;
    word_t       rd;
    word_t       data;
    word_t       base;
    logic [1:0]  off;
    logic [7:0]  tx_byte;
    enable = 1'b0;
    read_type = '0;
    write_type = '0;
    address = '0;
    data_in = '0;
    rst_n = 1'b0;
    err_count = 0;
    check_count = 0;
    test_count = 0;
    test_fail = 0;
    seed_val = $urandom(SEED);
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // leds dark after reset and then follow the low nibble
    begin_test("led");
    queue_check(1'b1, "led", {28'h0, led}, 32'hf);
    data = $urandom;
    repeat (2) begin
      bus_access(3'b000, 2'b11, ADDR_LED, data, rd);
      queue_check(1'b1, "led", {28'h0, led}, {28'h0, data[3:0]});
      // inverted nibble so every led takes both levels
      data = ~data;
    end
    // the led register reads as zero
    io_read_check(ADDR_LED, '0, "led_read");
    end_test();

    // random words anywhere below the I/O page
    begin_test("ram_word");
    for (int i = 0; i < N_RAND; i++) begin
      addrs.push_back($urandom & 32'h7fff_fffc);
      ram_write(2'b11, addrs[i], $urandom);
    end
    foreach (addrs[i]) begin
      ram_read_check(3'b011, addrs[i]);
    end
    end_test();

    // byte and aligned half merges with lanes read both ways
    begin_test("ram_lane");
    for (int i = 0; i < N_RAND; i++) begin
      pick = $urandom_range(N_RAND - 1, 0);
      if ($urandom_range(1, 0) == 1) begin
        off = 2'($urandom);
        base = {addrs[pick][31:2], off};
        ram_write(2'b01, base, $urandom);
        ram_read_check(3'b001, base);
        ram_read_check(3'b101, base);
      end else begin
        off = {1'($urandom), 1'b0};
        base = {addrs[pick][31:2], off};
        ram_write(2'b10, base, $urandom);
        ram_read_check(3'b010, base);
        ram_read_check(3'b110, base);
      end
      ram_read_check(3'b011, base);
    end
    end_test();

    // half word at odd offset
    begin_test("misaligned");
    for (int i = 0; i < N_MISAL; i++) begin
      pick = $urandom_range(N_RAND - 1, 0);
      base = {addrs[pick][31:2], 1'($urandom), 1'b1};
      ram_write(2'b10, base, $urandom);
      ram_read_check(3'b011, base);
      ram_read_check(3'b010, base);
      ram_read_check(3'b110, base);
    end
    end_test();

    // uart words start idle and each byte goes through the loopback
    begin_test("uart");
    io_read_check(ADDR_UART_OUT, UART_IDLE, "uart_out");
    io_read_check(ADDR_UART_IN, UART_IDLE, "uart_in");
    for (int i = 0; i < N_BYTES; i++) begin
      data = $urandom;
      tx_byte = data[7:0];
      bus_access(3'b000, 2'b11, ADDR_UART_OUT, data, rd);
      io_read_check(ADDR_UART_OUT, {24'h0, tx_byte}, "uart_out");
      // out word shows the byte until the frame is done
      polls = 0;
      rd = {24'h0, tx_byte};
      while (rd != UART_IDLE && polls < MAX_POLLS) begin
        bus_access(3'b011, 2'b00, ADDR_UART_OUT, '0, rd);
        if (rd != UART_IDLE) begin
          queue_check(1'b0, "uart_out", rd, {24'h0, tx_byte});
        end
        polls++;
      end
      if (rd != UART_IDLE) begin
        report_error("uart out word did not return to idle after the frame");
      end
      io_read_check(ADDR_UART_IN, {24'h0, tx_byte}, "uart_in");
      io_read_check(ADDR_UART_IN, UART_IDLE, "uart_in");
    end
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_count, test_fail, check_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // hard stop well past the expected run length
  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("error: run did not finish within %0d ns", TIMEOUT_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== ramio.f ====
rtl/ramio_pkg.sv
rtl/ramio_if.sv
rtl/word_ram.sv
rtl/io_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/bus_front.sv
rtl/ramio.sv
dv/tb_clk.sv
dv/ramio_sva.sv
dv/ramio_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ramio_tb -f ramio.f -o ramio_sim || exit 1
./obj_dir/ramio_sim | tee /dev/stderr | grep -x "TB PASSED" > /dev/null && exit 0 || exit 1
